// File: source/fsab_pkg.sv
package fsab_pkg;

	typedef enum logic {
		FSAB_READ  = 1'b0,
		FSAB_WRITE = 1'b1
	} fsab_mode_e;

	typedef logic [3:0]  fsab_did_t;	// device id, also the sub-id
	typedef logic [31:0] fsab_addr_t;	// byte address
	typedef logic [3:0]  fsab_len_t;	// request length in 64-bit words

	localparam int FSAB_LEN_MAX = 8;	// longest legal burst

	typedef logic [63:0] fsab_data_t;
	typedef logic [7:0]  fsab_mask_t;	// one enable per data byte

	localparam int FSAB_BYTES_PER_WORD = 8;

endpackage

// File: source/simmem_pkg.sv
package simmem_pkg;

	// one queued request, as taken from the header beat
	typedef struct packed {
		fsab_pkg::fsab_mode_e mode;
		fsab_pkg::fsab_did_t  did;
		fsab_pkg::fsab_did_t  subdid;
		fsab_pkg::fsab_addr_t addr;
		fsab_pkg::fsab_len_t  len;
	} simmem_hdr_t;

	// one queued data word with its byte enables
	typedef struct packed {
		fsab_pkg::fsab_data_t data;
		fsab_pkg::fsab_mask_t mask;
	} simmem_beat_t;

endpackage

// File: source/fsab_fifo.sv
`timescale 1ns/1ps

module fsab_fifo #(
	parameter int DEPTH = 4,
	parameter type payload_t = logic [7:0]
) (
	input  logic     clk,
	input  logic     Nrst,
	input  logic     push,
	input  payload_t push_data,
	input  logic     pop,
	output payload_t pop_data,
	output logic     empty
);

	localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

	payload_t    mem [DEPTH];
	logic [AW:0] wr_ptr;	// msb is the wrap bit
	logic [AW:0] rd_ptr;
	logic        full;

	// advance a pointer, flipping the wrap bit at the end of the buffer
	function automatic logic [AW:0] ptr_next(input logic [AW:0] ptr);
		logic [AW:0] nxt;
		nxt = ptr;
		if (ptr[AW-1:0] == AW'(DEPTH - 1)) begin
			nxt[AW-1:0] = '0;
			nxt[AW]     = ~ptr[AW];
		end else begin
			nxt[AW-1:0] = ptr[AW-1:0] + 1'b1;
		end
		return nxt;
	endfunction

	assign empty = (wr_ptr == rd_ptr);
	assign full  = (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]) && (wr_ptr[AW] != rd_ptr[AW]);

	always_ff @(posedge clk or negedge Nrst) begin
		if (!Nrst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (push && !full)
				wr_ptr <= ptr_next(wr_ptr);
			if (pop && !empty)
				rd_ptr <= ptr_next(rd_ptr);
		end
	end

	always_ff @(posedge clk) begin
		if (push && !full)
			mem[wr_ptr[AW-1:0]] <= push_data;
		if (pop && !empty)
			pop_data <= mem[rd_ptr[AW-1:0]];	// held until the next pop
	end

endmodule

// File: source/fsab_ingress.sv
`timescale 1ns/1ps

module fsab_ingress #(
	parameter int N_CREDITS = 4
) (
	input  logic                     clk,
	input  logic                     Nrst,
	input  logic                     fsabo_valid,
	input  fsab_pkg::fsab_mode_e     fsabo_mode,
	input  fsab_pkg::fsab_did_t      fsabo_did,
	input  fsab_pkg::fsab_did_t      fsabo_subdid,
	input  fsab_pkg::fsab_addr_t     fsabo_addr,
	input  fsab_pkg::fsab_len_t      fsabo_len,
	input  fsab_pkg::fsab_data_t     fsabo_data,
	input  fsab_pkg::fsab_mask_t     fsabo_mask,
	input  logic                     hdr_pop,
	output simmem_pkg::simmem_hdr_t  hdr,
	output logic                     hdr_empty,
	input  logic                     beat_pop,
	output simmem_pkg::simmem_beat_t beat
);

	import fsab_pkg::*;
	import simmem_pkg::*;

	fsab_len_t    burst_rem;	// write continuation beats still to come
	logic         hdr_beat;
	simmem_hdr_t  hdr_in;
	simmem_beat_t beat_in;

	assign hdr_beat = fsabo_valid && (burst_rem == '0);

	always_ff @(posedge clk or negedge Nrst) begin
		if (!Nrst) begin
			burst_rem <= '0;
		end else if (hdr_beat) begin
			// header carries the first word, so only len-1 beats follow
			if (fsabo_mode == FSAB_WRITE && fsabo_len != '0)
				burst_rem <= fsabo_len - 1'b1;
		end else if (fsabo_valid) begin
			burst_rem <= burst_rem - 1'b1;
		end
	end

	assign hdr_in = '{
		mode:   fsabo_mode,
		did:    fsabo_did,
		subdid: fsabo_subdid,
		addr:   fsabo_addr,
		len:    fsabo_len
	};

	assign beat_in = '{data: fsabo_data, mask: fsabo_mask};

	fsab_fifo #(
		.DEPTH     (N_CREDITS),
		.payload_t (simmem_hdr_t)
	) hdr_fifo (
		.clk       (clk),
		.Nrst      (Nrst),
		.push      (hdr_beat),
		.push_data (hdr_in),
		.pop       (hdr_pop),
		.pop_data  (hdr),
		.empty     (hdr_empty)
	);

	// every valid beat is queued, read headers included
	fsab_fifo #(
		.DEPTH     (N_CREDITS * FSAB_LEN_MAX),
		.payload_t (simmem_beat_t)
	) beat_fifo (
		.clk       (clk),
		.Nrst      (Nrst),
		.push      (fsabo_valid),
		.push_data (beat_in),
		.pop       (beat_pop),
		.pop_data  (beat),
		.empty     ()
	);

endmodule

// File: source/simmem_array.sv
`timescale 1ns/1ps

module simmem_array #(
	parameter int MEM_WORDS = 1024,
	localparam int IW = $clog2(MEM_WORDS)
) (
	input  logic                 clk,
	input  logic                 wr_en,
	input  logic [IW-1:0]        wr_index,
	input  fsab_pkg::fsab_data_t wr_data,
	input  fsab_pkg::fsab_mask_t wr_mask,
	input  logic [IW-1:0]        rd_index,
	output fsab_pkg::fsab_data_t rd_data
);

	import fsab_pkg::*;

	fsab_data_t mem [MEM_WORDS];
	fsab_data_t merged;	// stored word with the enabled bytes replaced

	initial begin
		for (int i = 0; i < MEM_WORDS; i++)
			mem[i] = '0;
	end

	always_comb begin
		merged = mem[wr_index];
		for (int b = 0; b < FSAB_BYTES_PER_WORD; b++) begin
			if (wr_mask[b])
				merged[b*8 +: 8] = wr_data[b*8 +: 8];
		end
	end

	always @(posedge clk) begin
		if (wr_en)
			mem[wr_index] <= merged;
	end

	assign rd_data = mem[rd_index];	// asynchronous read

endmodule

// File: source/simmem_ctrl.sv
`timescale 1ns/1ps

module simmem_ctrl #(
	parameter int MEM_WORDS = 1024,
	localparam int IW = $clog2(MEM_WORDS)
) (
	input  logic                     clk,
	input  logic                     Nrst,
	input  simmem_pkg::simmem_hdr_t  hdr,
	input  logic                     hdr_empty,
	output logic                     hdr_pop,
	input  simmem_pkg::simmem_beat_t beat,
	output logic                     beat_pop,
	output logic                     wr_en,
	output logic [IW-1:0]            wr_index,
	output fsab_pkg::fsab_data_t     wr_data,
	output fsab_pkg::fsab_mask_t     wr_mask,
	output logic [IW-1:0]            rd_index,
	input  fsab_pkg::fsab_data_t     rd_data,
	output logic                     fsabi_valid,
	output fsab_pkg::fsab_did_t      fsabi_did,
	output fsab_pkg::fsab_did_t      fsabi_subdid,
	output fsab_pkg::fsab_data_t     fsabi_data,
	output logic                     fsabo_credit
);

	import fsab_pkg::*;

	logic          active;	// a request is popped and not yet finished
	logic          active_d;
	fsab_len_t     len_rem;	// words left in the current request
	fsab_addr_t    cur_addr;	// byte address of the current word
	logic          loading;
	logic          working;
	logic [IW-1:0] word_index;

	// first active cycle waits for the registered FIFO outputs
	assign loading = active && !active_d;
	assign working = active && active_d;

	assign hdr_pop  = !active && !hdr_empty;
	// one beat leaves with every header, then the rest of a write burst
	assign beat_pop = hdr_pop ||
		(working && hdr.mode == FSAB_WRITE && len_rem != fsab_len_t'(1));

	always_ff @(posedge clk or negedge Nrst) begin
		if (!Nrst) begin
			active   <= 1'b0;
			active_d <= 1'b0;
			len_rem  <= '0;
			cur_addr <= '0;
		end else begin
			active_d <= active;

			if (hdr_pop)
				active <= 1'b1;
			else if (loading && hdr.len == '0)
				active <= 1'b0;	// zero length only returns its credit
			else if (working && len_rem == fsab_len_t'(1))
				active <= 1'b0;

			if (loading) begin
				len_rem  <= hdr.len;
				cur_addr <= hdr.addr;
			end else if (working) begin
				len_rem  <= len_rem - 1'b1;
				cur_addr <= cur_addr + fsab_addr_t'(FSAB_BYTES_PER_WORD);
			end
		end
	end

	assign word_index = IW'((cur_addr / fsab_addr_t'(FSAB_BYTES_PER_WORD)) %
		fsab_addr_t'(MEM_WORDS));

	assign wr_en    = working && hdr.mode == FSAB_WRITE;
	assign wr_index = word_index;
	assign wr_data  = beat.data;
	assign wr_mask  = beat.mask;
	assign rd_index = word_index;

	// read words go straight out, no back-pressure on the response side
	assign fsabi_valid  = working && hdr.mode == FSAB_READ;
	assign fsabi_did    = hdr.did;
	assign fsabi_subdid = hdr.subdid;
	assign fsabi_data   = rd_data;

	assign fsabo_credit = active_d && !active;	// cycle after the last active one

endmodule

// File: source/fsab_simmem.sv
`timescale 1ns/1ps

module fsab_simmem #(
	parameter int N_CREDITS = 4,
	parameter int MEM_WORDS = 1024
) (
	input  logic                 clk,
	input  logic                 Nrst,

	input  logic                 fsabo_valid,
	input  fsab_pkg::fsab_mode_e fsabo_mode,
	input  fsab_pkg::fsab_did_t  fsabo_did,
	input  fsab_pkg::fsab_did_t  fsabo_subdid,
	input  fsab_pkg::fsab_addr_t fsabo_addr,
	input  fsab_pkg::fsab_len_t  fsabo_len,
	input  fsab_pkg::fsab_data_t fsabo_data,
	input  fsab_pkg::fsab_mask_t fsabo_mask,
	output logic                 fsabo_credit,

	output logic                 fsabi_valid,
	output fsab_pkg::fsab_did_t  fsabi_did,
	output fsab_pkg::fsab_did_t  fsabi_subdid,
	output fsab_pkg::fsab_data_t fsabi_data
);

	import fsab_pkg::*;
	import simmem_pkg::*;

	localparam int IW = $clog2(MEM_WORDS);

	simmem_hdr_t   hdr;	// head of the request queue
	logic          hdr_empty;
	logic          hdr_pop;
	simmem_beat_t  beat;
	logic          beat_pop;
	logic          wr_en;
	logic [IW-1:0] wr_index;
	fsab_data_t    wr_data;
	fsab_mask_t    wr_mask;
	logic [IW-1:0] rd_index;
	fsab_data_t    rd_data;

	fsab_ingress #(
		.N_CREDITS (N_CREDITS)
	) ingress_inst (
		.clk          (clk),
		.Nrst         (Nrst),
		.fsabo_valid  (fsabo_valid),
		.fsabo_mode   (fsabo_mode),
		.fsabo_did    (fsabo_did),
		.fsabo_subdid (fsabo_subdid),
		.fsabo_addr   (fsabo_addr),
		.fsabo_len    (fsabo_len),
		.fsabo_data   (fsabo_data),
		.fsabo_mask   (fsabo_mask),
		.hdr_pop      (hdr_pop),
		.hdr          (hdr),
		.hdr_empty    (hdr_empty),
		.beat_pop     (beat_pop),
		.beat         (beat)
	);

	simmem_ctrl #(
		.MEM_WORDS (MEM_WORDS)
	) ctrl_inst (
		.clk          (clk),
		.Nrst         (Nrst),
		.hdr          (hdr),
		.hdr_empty    (hdr_empty),
		.hdr_pop      (hdr_pop),
		.beat         (beat),
		.beat_pop     (beat_pop),
		.wr_en        (wr_en),
		.wr_index     (wr_index),
		.wr_data      (wr_data),
		.wr_mask      (wr_mask),
		.rd_index     (rd_index),
		.rd_data      (rd_data),
		.fsabi_valid  (fsabi_valid),
		.fsabi_did    (fsabi_did),
		.fsabi_subdid (fsabi_subdid),
		.fsabi_data   (fsabi_data),
		.fsabo_credit (fsabo_credit)
	);

	simmem_array #(
		.MEM_WORDS (MEM_WORDS)
	) array_inst (
		.clk      (clk),
		.wr_en    (wr_en),
		.wr_index (wr_index),
		.wr_data  (wr_data),
		.wr_mask  (wr_mask),
		.rd_index (rd_index),
		.rd_data  (rd_data)
	);

endmodule

// File: tests/tb_fsab_model.svh
`ifndef TB_FSAB_MODEL_SVH
`define TB_FSAB_MODEL_SVH

fsab_data_t shadow [MEM_WORDS_TB];	// what the DUT storage should hold
fsab_data_t exp_data [$];	// read words still to come back, in order
fsab_did_t  exp_did [$];
fsab_did_t  exp_subdid [$];
int         n_errors = 0;
int         n_checks = 0;

initial begin
	for (int i = 0; i < MEM_WORDS_TB; i++)
		shadow[i] = '0;
end

// word index is the byte address over 8, wrapped to the storage depth
function automatic int word_of(input fsab_addr_t addr);
	return int'((addr / FSAB_BYTES_PER_WORD) % MEM_WORDS_TB);
endfunction

task automatic shadow_write(input fsab_addr_t addr, input fsab_data_t data,
		input fsab_mask_t mask);
	int idx;
	idx = word_of(addr);
	for (int b = 0; b < FSAB_BYTES_PER_WORD; b++) begin
		if (mask[b])
			shadow[idx][b*8 +: 8] = data[b*8 +: 8];	// only enabled bytes change
	end
endtask

task automatic expect_read(input fsab_addr_t addr, input fsab_did_t did,
		input fsab_did_t subdid, input fsab_len_t len);
	fsab_addr_t a;
	for (int k = 0; k < int'(len); k++) begin
		a = addr + fsab_addr_t'(k * FSAB_BYTES_PER_WORD);
		exp_data.push_back(shadow[word_of(a)]);
		exp_did.push_back(did);
		exp_subdid.push_back(subdid);
	end
endtask

task automatic check_word(input string name, input fsab_data_t got, input fsab_data_t exp);
	n_checks++;
	if (got !== exp) begin
		n_errors++;
		$display("ERR %0t %s got %h expected %h", $time, name, got, exp);
	end
endtask

task automatic check_id(input string name, input fsab_did_t got, input fsab_did_t exp);
	n_checks++;
	if (got !== exp) begin
		n_errors++;
		$display("ERR %0t %s got %h expected %h", $time, name, got, exp);
	end
endtask

task automatic check_count(input string name, input int got, input int exp);
	n_checks++;
	if (got != exp) begin
		n_errors++;
		$display("ERR %0t %s got %0d expected %0d", $time, name, got, exp);
	end
endtask

`endif

// File: tests/tb_fsab_simmem.sv
`timescale 1ns/1ps

module tb_fsab_simmem;

	import fsab_pkg::*;

	localparam int N_CREDITS_TB = 4;
	localparam int MEM_WORDS_TB = 256;

	logic       clk;
	logic       Nrst;
	logic       fsabo_valid;
	fsab_mode_e fsabo_mode;
	fsab_did_t  fsabo_did;
	fsab_did_t  fsabo_subdid;
	fsab_addr_t fsabo_addr;
	fsab_len_t  fsabo_len;
	fsab_data_t fsabo_data;
	fsab_mask_t fsabo_mask;
	logic       fsabo_credit;
	logic       fsabi_valid;
	fsab_did_t  fsabi_did;
	fsab_did_t  fsabi_subdid;
	fsab_data_t fsabi_data;

	integer     seed;
	int         credits;	// credits the requester holds
	int         credit_count;	// credit pulses seen so far
	int         resp_count;	// read words seen so far
	fsab_data_t last_word;	// most recent read word
	fsab_data_t wdata [FSAB_LEN_MAX];	// beats of the next request
	fsab_mask_t wmask [FSAB_LEN_MAX];

	`include "tb_fsab_model.svh"

	fsab_simmem #(
		.N_CREDITS (N_CREDITS_TB),
		.MEM_WORDS (MEM_WORDS_TB)
	) fsab_simmem_inst (
		.clk          (clk),
		.Nrst         (Nrst),
		.fsabo_valid  (fsabo_valid),
		.fsabo_mode   (fsabo_mode),
		.fsabo_did    (fsabo_did),
		.fsabo_subdid (fsabo_subdid),
		.fsabo_addr   (fsabo_addr),
		.fsabo_len    (fsabo_len),
		.fsabo_data   (fsabo_data),
		.fsabo_mask   (fsabo_mask),
		.fsabo_credit (fsabo_credit),
		.fsabi_valid  (fsabi_valid),
		.fsabi_did    (fsabi_did),
		.fsabi_subdid (fsabi_subdid),
		.fsabi_data   (fsabi_data)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// responses sampled mid-cycle, away from the driving edge
	always @(negedge clk) begin
		if (Nrst) begin
			if (fsabi_valid) begin
				resp_count++;
				last_word = fsabi_data;
				if (exp_data.size() == 0) begin
					n_errors++;
					$display("read response at %0t while no read was outstanding", $time);
				end else begin
					check_word("fsabi_data", fsabi_data, exp_data.pop_front());
					check_id("fsabi_did", fsabi_did, exp_did.pop_front());
					check_id("fsabi_subdid", fsabi_subdid, exp_subdid.pop_front());
				end
			end
			if (fsabo_credit) begin
				credits++;
				credit_count++;
			end
		end
	end

	task automatic fill_beats(input logic rand_mask);
		for (int k = 0; k < FSAB_LEN_MAX; k++) begin
			wdata[k] = {$random(seed), $random(seed)};
			wmask[k] = rand_mask ? fsab_mask_t'($random(seed)) : 8'hff;
		end
	endtask

	task automatic wait_credit;
		int guard;
		guard = 0;
		while (credits == 0 && guard < 500) begin
			@(posedge clk);
			#1;
			guard++;
		end
		if (credits == 0) begin
			n_errors++;
			$display("timeout at %0t: no credit came back", $time);
		end
	endtask

	task automatic send_req(input fsab_mode_e mode, input fsab_did_t did,
			input fsab_did_t subdid, input fsab_addr_t addr, input fsab_len_t len);
		int nbeats;
		wait_credit();
		if (credits == 0)
			return;
		credits--;	// spent on the header beat
		nbeats = (mode == FSAB_WRITE && len != '0) ? int'(len) : 1;
		if (mode == FSAB_READ)
			expect_read(addr, did, subdid, len);
		for (int k = 0; k < nbeats; k++) begin
			fsabo_valid  = 1'b1;
			fsabo_mode   = mode;
			fsabo_did    = did;
			fsabo_subdid = subdid;
			fsabo_addr   = addr;
			fsabo_len    = len;
			fsabo_data   = wdata[k];
			fsabo_mask   = wmask[k];
			if (mode == FSAB_WRITE && len != '0)
				shadow_write(addr + fsab_addr_t'(k * FSAB_BYTES_PER_WORD), wdata[k], wmask[k]);
			@(posedge clk);
			#1;
		end
		fsabo_valid = 1'b0;
	endtask

	task automatic wait_drain;
		int guard;
		guard = 0;
		while ((credits != N_CREDITS_TB || exp_data.size() != 0) && guard < 2000) begin
			@(posedge clk);
			#1;
			guard++;
		end
		if (credits != N_CREDITS_TB || exp_data.size() != 0) begin
			n_errors++;
			$display("timeout at %0t: requests still outstanding", $time);
		end
	endtask

	task automatic report_test(input int num, input string name, input int err_before);
		$display("test %0d %s: %0s", num, name, (n_errors == err_before) ? "ok" : "FAILED");
	endtask

	initial begin
		int         e0;
		int         c0;
		int         r0;
		fsab_addr_t a;
		fsab_mode_e mode;
		seed         = 32'h1c2d_0343;
		Nrst         = 1'b0;
		fsabo_valid  = 1'b0;
		fsabo_mode   = FSAB_READ;
		fsabo_did    = '0;
		fsabo_subdid = '0;
		fsabo_addr   = '0;
		fsabo_len    = '0;
		fsabo_data   = '0;
		fsabo_mask   = '0;
		credits      = N_CREDITS_TB;
		credit_count = 0;
		resp_count   = 0;
		last_word    = '0;
		repeat (5) @(posedge clk);
		#1;
		Nrst = 1'b1;

		e0 = n_errors;
		c0 = credit_count;
		r0 = resp_count;
		repeat (10) @(posedge clk);
		#1;
		check_count("idle fsabi_valid pulses", resp_count - r0, 0);
		check_count("idle fsabo_credit pulses", credit_count - c0, 0);
		fill_beats(1'b0);
		send_req(FSAB_READ, 4'h3, 4'h9, fsab_addr_t'($random(seed)), 4'd1);
		wait_drain();
		check_count("words after first read", resp_count - r0, 1);
		report_test(1, "reset and idle read", e0);

		e0 = n_errors;
		fill_beats(1'b0);
		send_req(FSAB_WRITE, 4'h1, 4'h2, 32'h0000_0100, 4'd1);
		send_req(FSAB_READ, 4'h1, 4'h2, 32'h0000_0100, 4'd1);
		wait_drain();
		report_test(2, "full mask write and read back", e0);

		e0 = n_errors;
		wdata[0] = 64'h1111_2222_3333_4444;
		wmask[0] = 8'hff;
		send_req(FSAB_WRITE, 4'h5, 4'h6, 32'h0000_0200, 4'd1);
		wdata[0] = 64'haaaa_bbbb_cccc_dddd;
		wmask[0] = 8'b0101_1010;	// bytes 1, 3, 4 and 6 replaced
		send_req(FSAB_WRITE, 4'h5, 4'h6, 32'h0000_0200, 4'd1);
		send_req(FSAB_READ, 4'h7, 4'h8, 32'h0000_0200, 4'd1);
		wait_drain();
		check_word("merged fsabi_data", last_word, 64'h11aa_22bb_cc33_dd44);
		report_test(3, "partial mask merge", e0);

		e0 = n_errors;
		for (int len = 1; len <= FSAB_LEN_MAX; len++) begin
			a = fsab_addr_t'($random(seed));
			fill_beats(1'b0);
			send_req(FSAB_WRITE, fsab_did_t'($random(seed)), fsab_did_t'($random(seed)),
				a, fsab_len_t'(len));
			send_req(FSAB_READ, fsab_did_t'($random(seed)), fsab_did_t'($random(seed)),
				a, fsab_len_t'(len));
		end
		wait_drain();
		report_test(4, "bursts of length 1 to 8", e0);

		e0 = n_errors;
		c0 = credit_count;
		r0 = resp_count;
		fill_beats(1'b1);
		send_req(FSAB_READ, 4'h2, 4'h4, 32'h0000_0040, 4'd0);	// all 4 credits spent in a row
		send_req(FSAB_WRITE, 4'h2, 4'h4, 32'h0000_0040, 4'd0);
		send_req(FSAB_READ, 4'h2, 4'h4, 32'h0000_0300, 4'd2);
		send_req(FSAB_WRITE, 4'h2, 4'h4, 32'h0000_0300, 4'd3);
		wait_drain();
		check_count("credits returned", credit_count - c0, 4);
		check_count("read words returned", resp_count - r0, 2);
		report_test(5, "credit accounting", e0);

		e0 = n_errors;
		repeat (300) begin
			mode = ($random(seed) & 1) ? FSAB_WRITE : FSAB_READ;
			a    = fsab_addr_t'($random(seed));
			fill_beats(1'b1);
			send_req(mode, fsab_did_t'($random(seed)), fsab_did_t'($random(seed)),
				a, fsab_len_t'({$random(seed)} % (FSAB_LEN_MAX + 1)));
		end
		wait_drain();
		check_count("expected reads left", exp_data.size(), 0);
		check_count("credit balance", credits, N_CREDITS_TB);
		report_test(6, "random mixed requests", e0);

		$display("checks %0d, errors %0d", n_checks, n_errors);
		if (n_errors == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

// File: sources.f
source/fsab_pkg.sv
source/simmem_pkg.sv
source/fsab_fifo.sv
source/fsab_ingress.sv
source/simmem_array.sv
source/simmem_ctrl.sv
source/fsab_simmem.sv
+incdir+tests
tests/tb_fsab_simmem.sv

// File: run_sim.sh
#!/bin/bash
# compile with Verilator, run, and decide on the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir
verilator --binary --timing -Wno-fatal -f sources.f --top-module tb_fsab_simmem \
	> build.log 2>&1 \
	&& ./obj_dir/Vtb_fsab_simmem > sim.log 2>&1 \
	&& grep -qx "Finished with no errors" sim.log \
	&& echo "PASS" \
	|| { echo "FAIL (see build.log and sim.log)"; exit 1; }
